// ==== fp_pkg.sv ====
package fp_pkg;

    // Single-precision field widths
    localparam int FP_W  = 32;
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;

    // Exponent of 1.0
    localparam logic [EXP_W-1:0] EXP_BIAS = 8'd127;

    // From this exponent up there are no fraction bits left
    localparam logic [EXP_W-1:0] EXP_INT = 8'd150;

    // Rounding direction
    localparam logic MODE_FLOOR = 1'b0;
    localparam logic MODE_CEIL  = 1'b1;

endpackage

// ==== wb_pkg.sv ====
package wb_pkg;

    localparam int ADR_W     = 8;   // Word address
    localparam int DAT_W     = 32;
    localparam int BUF_DEPTH = 16;
    localparam int IDX_W     = 4;
    localparam int CNT_W     = 5;   // Holds 0 to BUF_DEPTH

    // Register map, word addresses
    localparam logic [ADR_W-1:0] REG_CTRL   = 8'h00;
    localparam logic [ADR_W-1:0] REG_COUNT  = 8'h01;
    localparam logic [ADR_W-1:0] REG_STATUS = 8'h02;
    localparam logic [ADR_W-1:0] OPND_BASE  = 8'h40;
    localparam logic [ADR_W-1:0] RSLT_BASE  = 8'h80;

    // Bit positions in CTRL and STATUS
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_MODE_BIT  = 1;
    localparam int STAT_BUSY_BIT  = 0;
    localparam int STAT_DONE_BIT  = 1;

endpackage

// ==== fp_floor.sv ====
`timescale 1ns/1ns

module fp_floor (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [fp_pkg::FP_W-1:0] a,
    input  logic                    mode,
    output logic [fp_pkg::FP_W-1:0] c
);
    import fp_pkg::*;

    logic             flip;
    logic             s;
    logic [EXP_W-1:0] e;
    logic [MAN_W-1:0] m;
    logic             below_one;
    logic             is_int;
    logic [EXP_W-1:0] frac_n;
    logic [MAN_W:0]   frac_unit;
    logic [MAN_W:0]   frac_mask;
    logic             has_frac;
    logic [MAN_W-1:0] m_trunc;
    logic [MAN_W+1:0] m_up;
    logic [EXP_W-1:0] ep1;
    logic [FP_W-1:0]  r;

    // Ceil(x) = -floor(-x)
    assign flip = (mode == MODE_CEIL);
    assign s    = a[FP_W-1] ^ flip;
    assign e    = a[FP_W-2:MAN_W];
    assign m    = a[MAN_W-1:0];

    assign below_one = e < EXP_BIAS;
    assign is_int    = e >= EXP_INT;   // Also NaN and infinity
    assign ep1       = e + 1'b1;

    // Number of fraction bits in the mantissa, 1 to 23 in the middle range
    assign frac_n    = EXP_INT - e;
    assign frac_unit = (MAN_W+1)'(1) << frac_n;
    assign frac_mask = frac_unit - 1'b1;

    assign has_frac = |(m & frac_mask[MAN_W-1:0]);
    assign m_trunc  = m & ~frac_mask[MAN_W-1:0];

    // Significand with hidden bit, bumped by one integer unit
    assign m_up = {2'b01, m_trunc} + {1'b0, frac_unit};

    always_comb begin
        if (is_int) begin
            r = {s, e, m};
        end else if (below_one) begin
            r = s ? {1'b1, EXP_BIAS, {MAN_W{1'b0}}} : '0;   // -1.0 or +0
        end else if (!s || !has_frac) begin
            r = {s, e, m_trunc};
        end else if (m_up[MAN_W+1]) begin
            r = {1'b1, ep1, {MAN_W{1'b0}}};   // Carry into the next binade
        end else begin
            r = {1'b1, e, m_up[MAN_W-1:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            c <= '0;
        end else begin
            c <= {r[FP_W-1] ^ flip, r[FP_W-2:0]};
        end
    end

endmodule

// ==== word_buffer.sv ====
`timescale 1ns/1ns

module word_buffer (
    input  logic                     clk,
    input  logic                     we,
    input  logic [wb_pkg::IDX_W-1:0] wr_idx,
    input  logic [wb_pkg::DAT_W-1:0] wr_data,
    input  logic [wb_pkg::IDX_W-1:0] rd_idx,
    output logic [wb_pkg::DAT_W-1:0] rd_data
);
    import wb_pkg::*;

    logic [DAT_W-1:0] mem [BUF_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
        rd_data <= mem[rd_idx];   // One cycle read
    end

endmodule

// ==== batch_counter.sv ====
`timescale 1ns/1ns

module batch_counter (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     clear,
    input  logic                     issue,
    input  logic [wb_pkg::CNT_W-1:0] count,
    output logic [wb_pkg::IDX_W-1:0] rd_idx,
    output logic                     wr_en,
    output logic [wb_pkg::IDX_W-1:0] wr_idx,
    output logic                     last_issue,
    output logic                     drained
);
    import wb_pkg::*;

    logic [CNT_W-1:0] issue_cnt;
    logic [CNT_W-1:0] retire_cnt;
    logic [CNT_W-1:0] retire_now;
    logic             op_valid;   // Operand at datapath input

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            issue_cnt  <= '0;
            retire_cnt <= '0;
            op_valid   <= 1'b0;
            wr_en      <= 1'b0;
        end else begin
            if (issue) begin
                issue_cnt <= issue_cnt + 1'b1;
            end
            if (wr_en) begin
                retire_cnt <= retire_cnt + 1'b1;
            end
            op_valid <= issue;
            wr_en    <= op_valid;   // Datapath result registered
        end
    end

    assign rd_idx = issue_cnt[IDX_W-1:0];
    assign wr_idx = retire_cnt[IDX_W-1:0];

    assign last_issue = (issue_cnt + 1'b1) == count;

    // Look through a pending clear so an empty batch is drained at once
    assign retire_now = clear ? '0 : retire_cnt;
    assign drained    = retire_now == count;

endmodule

// ==== batch_fsm.sv ====
`timescale 1ns/1ns

module batch_fsm (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic last_issue,
    input  logic drained,
    output logic clear,
    output logic issue,
    output logic busy,
    output logic done
);

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DRAIN,
        DONE
    } state_t;

    state_t state;
    state_t next_state;

    assign clear = start && (state == IDLE || state == DONE);
    assign issue = (state == RUN);
    assign busy  = (state == RUN) || (state == DRAIN);
    assign done  = (state == DONE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE, DONE: begin
                if (start) begin
                    next_state = drained ? DONE : RUN;   // Count of zero
                end
            end
            RUN: begin
                if (last_issue) begin
                    next_state = DRAIN;
                end
            end
            DRAIN: begin
                if (drained) begin
                    next_state = DONE;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

endmodule

// ==== wb_regs.sv ====
`timescale 1ns/1ns

module wb_regs (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [wb_pkg::ADR_W-1:0]   adr,
    input  logic [wb_pkg::DAT_W-1:0]   dat_w,
    input  logic [wb_pkg::DAT_W/8-1:0] sel,   // Byte lanes ignored
    output logic [wb_pkg::DAT_W-1:0]   dat_r,
    output logic                       ack,
    input  logic                       busy,
    input  logic                       done,
    output logic                       start,
    output logic                       mode,
    output logic [wb_pkg::CNT_W-1:0]   count,
    output logic                       opnd_we,
    output logic [wb_pkg::IDX_W-1:0]   opnd_idx,
    output logic [wb_pkg::DAT_W-1:0]   opnd_data,
    output logic [wb_pkg::IDX_W-1:0]   rslt_idx,
    input  logic [wb_pkg::DAT_W-1:0]   rslt_data
);
    import wb_pkg::*;
    import fp_pkg::*;

    logic             req;
    logic             wr_req;
    logic             opnd_hit;
    logic             rslt_hit;
    logic             rd_rslt;
    logic [DAT_W-1:0] rd_hold;
    logic [DAT_W-1:0] reg_rdata;

    // New request, not yet acknowledged
    assign req    = cyc && stb && !ack;
    assign wr_req = req && we;

    assign opnd_hit = adr[ADR_W-1:IDX_W] == OPND_BASE[ADR_W-1:IDX_W];
    assign rslt_hit = adr[ADR_W-1:IDX_W] == RSLT_BASE[ADR_W-1:IDX_W];

    assign opnd_we   = wr_req && opnd_hit && !busy;
    assign opnd_idx  = adr[IDX_W-1:0];
    assign opnd_data = dat_w;
    assign rslt_idx  = adr[IDX_W-1:0];   // Read issued in the request cycle

    assign start = wr_req && (adr == REG_CTRL) && dat_w[CTRL_START_BIT] && !busy;

    always_comb begin
        reg_rdata = '0;
        case (adr)
            REG_CTRL:   reg_rdata[CTRL_MODE_BIT] = mode;
            REG_COUNT:  reg_rdata[CNT_W-1:0] = count;
            REG_STATUS: begin
                reg_rdata[STAT_BUSY_BIT] = busy;
                reg_rdata[STAT_DONE_BIT] = done;
            end
            default:    reg_rdata = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack   <= 1'b0;
            mode  <= MODE_FLOOR;
            count <= '0;
        end else begin
            ack <= req;
            if (wr_req && (adr == REG_CTRL) && !busy) begin
                mode <= dat_w[CTRL_MODE_BIT];
            end
            if (wr_req && (adr == REG_COUNT) && !busy) begin
                // Clamp to the buffer size
                count <= (dat_w > BUF_DEPTH) ? CNT_W'(BUF_DEPTH) : dat_w[CNT_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (req && !we) begin
            rd_rslt <= rslt_hit;
            rd_hold <= reg_rdata;
        end
    end

    // Valid while ack is high
    assign dat_r = rd_rslt ? rslt_data : rd_hold;

endmodule

// ==== round_engine_top.sv ====
`timescale 1ns/1ns

module round_engine_top (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cyc,
    input  logic                       stb,
    input  logic                       we,
    input  logic [wb_pkg::ADR_W-1:0]   adr,
    input  logic [wb_pkg::DAT_W-1:0]   dat_w,
    input  logic [wb_pkg::DAT_W/8-1:0] sel,
    output logic [wb_pkg::DAT_W-1:0]   dat_r,
    output logic                       ack
);
    import wb_pkg::*;

    logic             start;
    logic             mode;
    logic [CNT_W-1:0] count;
    logic             busy;
    logic             done;
    logic             clear;
    logic             issue;
    logic             last_issue;
    logic             drained;

    logic             opnd_we;
    logic [IDX_W-1:0] opnd_wr_idx;
    logic [DAT_W-1:0] opnd_wr_data;
    logic [IDX_W-1:0] opnd_rd_idx;
    logic [DAT_W-1:0] opnd_rd_data;

    logic             rslt_we;
    logic [IDX_W-1:0] rslt_wr_idx;
    logic [DAT_W-1:0] rslt_wr_data;
    logic [IDX_W-1:0] rslt_rd_idx;
    logic [DAT_W-1:0] rslt_rd_data;

    wb_regs u_wb_regs (
        .clk       (clk),
        .rst       (rst),
        .cyc       (cyc),
        .stb       (stb),
        .we        (we),
        .adr       (adr),
        .dat_w     (dat_w),
        .sel       (sel),
        .dat_r     (dat_r),
        .ack       (ack),
        .busy      (busy),
        .done      (done),
        .start     (start),
        .mode      (mode),
        .count     (count),
        .opnd_we   (opnd_we),
        .opnd_idx  (opnd_wr_idx),
        .opnd_data (opnd_wr_data),
        .rslt_idx  (rslt_rd_idx),
        .rslt_data (rslt_rd_data)
    );

    word_buffer opnd_buf (
        .clk     (clk),
        .we      (opnd_we),
        .wr_idx  (opnd_wr_idx),
        .wr_data (opnd_wr_data),
        .rd_idx  (opnd_rd_idx),
        .rd_data (opnd_rd_data)
    );

    word_buffer rslt_buf (
        .clk     (clk),
        .we      (rslt_we),
        .wr_idx  (rslt_wr_idx),
        .wr_data (rslt_wr_data),
        .rd_idx  (rslt_rd_idx),
        .rd_data (rslt_rd_data)
    );

    batch_counter u_batch_counter (
        .clk        (clk),
        .rst        (rst),
        .clear      (clear),
        .issue      (issue),
        .count      (count),
        .rd_idx     (opnd_rd_idx),
        .wr_en      (rslt_we),
        .wr_idx     (rslt_wr_idx),
        .last_issue (last_issue),
        .drained    (drained)
    );

    batch_fsm u_batch_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .last_issue (last_issue),
        .drained    (drained),
        .clear      (clear),
        .issue      (issue),
        .busy       (busy),
        .done       (done)
    );

    fp_floor u_fp_floor (
        .clk  (clk),
        .rst  (rst),
        .a    (opnd_rd_data),
        .mode (mode),
        .c    (rslt_wr_data)
    );

endmodule

// ==== tb_round_engine.sv ====
`timescale 1ns/1ns

module tb_round_engine;
    import fp_pkg::*;
    import wb_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 4;
    localparam int ACK_LIMIT     = 8;
    localparam int POLL_LIMIT    = 64;
    localparam int ACCESS_BUDGET = 300;   // All tests together, with margin
    // Each access spans three clock cycles
    localparam int WATCHDOG_NS   = (RESET_CYCLES + 3 * ACCESS_BUDGET) * CLK_PERIOD;

    // 2.5, -2.5, 0.3, -0.3, -1.5, 1e9, +inf, -inf
    localparam logic [31:0] FIXED_IN [8] = '{
        32'h4020_0000, 32'hc020_0000, 32'h3e99_999a, 32'hbe99_999a,
        32'hbfc0_0000, 32'h4e6e_6b28, 32'h7f80_0000, 32'hff80_0000
    };
    localparam logic [31:0] FIXED_FLOOR [8] = '{
        32'h4000_0000, 32'hc040_0000, 32'h0000_0000, 32'hbf80_0000,
        32'hc000_0000, 32'h4e6e_6b28, 32'h7f80_0000, 32'hff80_0000
    };

    logic             clk = 1'b0;
    logic             rst;
    logic             cyc;
    logic             stb;
    logic             we;
    logic [ADR_W-1:0] adr;
    logic [DAT_W-1:0] dat_w;
    logic [3:0]       sel;
    logic [DAT_W-1:0] dat_r;
    logic             ack;

    int          errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    logic [31:0] rnd_state = 32'hf825;
    logic [31:0] opnd [BUF_DEPTH];

    always #(CLK_PERIOD / 2) clk = ~clk;

    round_engine_top dut (
        .clk   (clk),
        .rst   (rst),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .dat_w (dat_w),
        .sel   (sel),
        .dat_r (dat_r),
        .ack   (ack)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Shift out the fraction as an integer, then renormalize
    function automatic logic [31:0] floor_ref(input logic [31:0] x);
        logic        s;
        logic [7:0]  e;
        logic [23:0] sig;
        logic [23:0] mag;
        logic [4:0]  sh;
        logic [4:0]  msb;
        logic [5:0]  i;
        logic [23:0] norm;
        s   = x[31];
        e   = x[30:23];
        sig = {1'b1, x[22:0]};
        if (e >= EXP_INT) begin
            return x;
        end
        if (e < EXP_BIAS) begin
            return s ? 32'hbf80_0000 : 32'h0000_0000;
        end
        sh  = 5'(EXP_INT - e);
        mag = sig >> sh;
        if (s && ((mag << sh) != sig)) begin
            mag = mag + 24'd1;   // Negative with a fraction moves away from zero
        end
        msb = 5'd0;
        for (i = 6'd0; i < 6'd24; i = i + 6'd1) begin
            if (mag[i]) begin
                msb = i[4:0];
            end
        end
        norm = mag << (5'd23 - msb);
        return {s, EXP_BIAS + {3'b000, msb}, norm[22:0]};
    endfunction

    function automatic logic [31:0] round_ref(input logic [31:0] x, input logic m);
        logic        flip;
        logic [31:0] y;
        flip = (m == MODE_CEIL);
        y    = floor_ref({x[31] ^ flip, x[30:0]});
        return {y[31] ^ flip, y[30:0]};
    endfunction

    task automatic wb_access(input logic wr, input logic [ADR_W-1:0] addr,
                             input logic [DAT_W-1:0] wdata, output logic [DAT_W-1:0] rdata);
        int waited;
        waited = 0;
        @(negedge clk);
        cyc   = 1'b1;
        stb   = 1'b1;
        we    = wr;
        adr   = addr;
        dat_w = wdata;
        do begin
            @(negedge clk);
            waited++;
        end while (!ack && waited < ACK_LIMIT);
        assert (ack === 1'b1) else begin
            $display("No acknowledge for address %02h at %0t ns", addr, $time);
            errors++;
        end
        rdata = dat_r;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        @(negedge clk);
        assert (ack === 1'b0) else begin
            $display("Address %02h acknowledged more than once at %0t ns", addr, $time);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] addr, input logic [DAT_W-1:0] data);
        logic [DAT_W-1:0] unused;
        wb_access(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] addr, output logic [DAT_W-1:0] data);
        wb_access(1'b0, addr, '0, data);
    endtask

    task automatic check_word(input logic [ADR_W-1:0] addr, input logic [31:0] got,
                              input logic [31:0] exp);
        assert (got === exp) else begin
            $display("mismatch at %0t ns: address %02h read %08h, expected %08h",
                     $time, addr, got, exp);
            errors++;
        end
    endtask

    task automatic start_batch(input logic m, input int n);
        logic [DAT_W-1:0] ctrl;
        ctrl = '0;
        ctrl[CTRL_START_BIT] = 1'b1;
        ctrl[CTRL_MODE_BIT]  = m;
        wb_write(REG_COUNT, DAT_W'(n));
        wb_write(REG_CTRL, ctrl);
    endtask

    task automatic poll_done();
        logic [DAT_W-1:0] status;
        int polls;
        status = '0;
        polls  = 0;
        while (!status[STAT_DONE_BIT] && polls < POLL_LIMIT) begin
            wb_read(REG_STATUS, status);
            polls++;
        end
        assert (status[STAT_DONE_BIT]) else begin
            $display("Done flag still low after %0d status polls at %0t ns", polls, $time);
            errors++;
        end
    endtask

    task automatic load_operands(input int n);
        for (int i = 0; i < n; i++) begin
            wb_write(OPND_BASE + ADR_W'(i), opnd[i]);
        end
    endtask

    task automatic check_results(input logic m, input int n);
        logic [DAT_W-1:0] got;
        for (int i = 0; i < n; i++) begin
            wb_read(RSLT_BASE + ADR_W'(i), got);
            check_word(RSLT_BASE + ADR_W'(i), got, round_ref(opnd[i], m));
        end
    endtask

    // Exponents 120 to 151 reach every branch of the rounding rule
    task automatic fill_random();
        logic [31:0] r;
        for (int i = 0; i < BUF_DEPTH; i++) begin
            rnd_state = lcg_step(rnd_state);
            r = rnd_state ^ {16'h0000, rnd_state[31:16]};
            opnd[i] = {r[31], 8'd120 + {3'b000, r[27:23]}, r[22:0]};
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - err_before);
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: run still going after %0d ns", WATCHDOG_NS);
        $display("Verification failed");
        $finish;
    end

    initial begin
        logic [DAT_W-1:0] rd;
        int err_before;
        rst   = 1'b1;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        dat_w = '0;
        sel   = 4'hf;

        err_before = errors;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
        repeat (4) begin
            @(negedge clk);
            assert (ack === 1'b0) else begin
                $display("Ack high with no active cycle at %0t ns", $time);
                errors++;
            end
        end
        wb_read(REG_STATUS, rd);
        check_word(REG_STATUS, rd, 32'h0);
        end_test("reset", err_before);

        // Done can only come from the empty start here, the FSM is still idle
        err_before = errors;
        start_batch(MODE_FLOOR, 0);
        wb_read(REG_STATUS, rd);
        check_word(REG_STATUS, rd, 32'h2);
        end_test("empty_batch", err_before);

        err_before = errors;
        for (int i = 0; i < 8; i++) begin
            opnd[i] = FIXED_IN[i];
            check_word(8'h00, round_ref(FIXED_IN[i], MODE_FLOOR), FIXED_FLOOR[i]);   // Model itself
        end
        load_operands(8);
        start_batch(MODE_FLOOR, 8);
        poll_done();
        check_results(MODE_FLOOR, 8);
        end_test("fixed_floor", err_before);

        err_before = errors;
        start_batch(MODE_CEIL, 8);
        poll_done();
        check_results(MODE_CEIL, 8);
        end_test("fixed_ceil", err_before);

        err_before = errors;
        fill_random();
        load_operands(BUF_DEPTH);
        start_batch(MODE_FLOOR, BUF_DEPTH);
        poll_done();
        check_results(MODE_FLOOR, BUF_DEPTH);
        start_batch(MODE_CEIL, BUF_DEPTH);
        poll_done();
        check_results(MODE_CEIL, BUF_DEPTH);
        end_test("random_batch", err_before);

        err_before = errors;
        fill_random();
        load_operands(BUF_DEPTH);
        start_batch(MODE_FLOOR, BUF_DEPTH);
        wb_read(REG_STATUS, rd);
        check_word(REG_STATUS, rd, 32'h1);
        // Dropped while the batch runs
        wb_write(OPND_BASE, 32'hdead_beef);
        wb_write(OPND_BASE + 8'h05, 32'h1234_5678);
        wb_write(REG_COUNT, 32'h3);
        poll_done();
        wb_read(REG_COUNT, rd);
        check_word(REG_COUNT, rd, 32'h10);
        check_results(MODE_FLOOR, BUF_DEPTH);
        start_batch(MODE_FLOOR, BUF_DEPTH);
        poll_done();
        check_results(MODE_FLOOR, BUF_DEPTH);
        end_test("busy_writes", err_before);

        err_before = errors;
        foreach (FIXED_IN[i]) begin
            wb_read(8'h03 + ADR_W'(i * 29), rd);   // Steps over register and buffer holes
            check_word(8'h03 + ADR_W'(i * 29), rd, 32'h0);
        end
        end_test("unmapped", err_before);

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// ==== list.f ====
fp_pkg.sv
wb_pkg.sv
fp_floor.sv
word_buffer.sv
batch_counter.sv
batch_fsm.sv
wb_regs.sv
round_engine_top.sv
tb_round_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the round engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_round_engine -f list.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_round_engine)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
    exit 0
fi
exit 1
